/* Makefile */
# Verilator flow for the control-domain command path

VERILATOR ?= verilator
TOP       ?= hl_ctrl_tb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* files.f */
+incdir+verilog
verilog/hl_ctrl_pkg.sv
verilog/cmd_sync.sv
verilog/ctrl_regs.sv
verilog/status_resp.sv
verilog/hl_ctrl_top.sv
test/tb_clkgen.sv
test/hl_ctrl_properties.sv
test/hl_ctrl_tb.sv

/* test/hl_ctrl_properties.sv */
/*
 * Response handshake, clear pulse and PA keying assertions
 */
module hl_ctrl_properties (
  input logic                    clk_ctrl,
  input logic                    arst_n_i,
  input hl_ctrl_pkg::ctrl_t      ctrl_i,
  input hl_ctrl_pkg::resp_t      resp_i,
  input logic                    resp_valid_i,
  input logic                    resp_ready_i,
  input logic                    rxclrstatus_i
);

  // Pending response must not move
  resp_hold_a: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i |=> $stable(resp_i))
    else $error("resp_o changed while the response waited for ready");

  // PA keyed only while transmitting
  pa_key_a: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    !(ctrl_i.pa_tr && !ctrl_i.tx_on))
    else $error("pa_tr high while tx_on is low");

  ////////////////////
  // Clear pulse

  clr_after_xfer_a: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    rxclrstatus_i |-> $past(resp_valid_i && resp_ready_i))
    else $error("rxclrstatus_o pulsed without a transfer on the cycle before");

  xfer_then_clr_a: assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    resp_valid_i && resp_ready_i |=> rxclrstatus_i)
    else $error("transfer not followed by an rxclrstatus_o pulse");

endmodule

/* test/hl_ctrl_tb.sv */
/*
 * Table-driven testbench for the control-domain command path
 * Compare tasks, LCG fill of reserved bits, cycle limit, report
 */
`include "hl_ctrl_config.svh"

module hl_ctrl_tb;

  localparam int          NUM_ROWS       = 7;
  localparam int          TIMEOUT_CYCLES = 20 * NUM_ROWS + 50;
  localparam logic [31:0] SEED           = 32'd54600;
  localparam logic [1:0]  RDY_NONE       = 2'd0;
  localparam logic [1:0]  RDY_NOW        = 2'd1;
  localparam logic [1:0]  RDY_HOLD       = 2'd2;
  localparam logic [5:0]  A_DRV          = `HL_ADDR_TXDRV;
  localparam logic [5:0]  A_GAIN         = `HL_ADDR_GAIN;
  localparam logic [5:0]  A_UNK          = 6'd5;
  localparam logic [5:0]  A_NONE         = 6'h3f;

  // One table row: stimulus, ready behavior and expected results
  typedef struct packed {
    hl_ctrl_pkg::cmd_t       cmd;
    hl_ctrl_pkg::rx_status_t status;
    logic [1:0]              ready_mode;
    hl_ctrl_pkg::ctrl_t      exp_ctrl;
    hl_ctrl_pkg::resp_t      exp_resp;
  } row_t;

  logic                    clk_ctrl;
  logic                    arst_n_i;
  hl_ctrl_pkg::cmd_t       cmd_i;
  logic                    cmd_cnt_i;
  hl_ctrl_pkg::rx_status_t status_i;
  hl_ctrl_pkg::ctrl_t      ctrl_o;
  hl_ctrl_pkg::resp_t      resp_o;
  logic                    resp_valid_o;
  logic                    resp_ready_i;
  logic                    rxclrstatus_o;

  row_t               rows [NUM_ROWS];
  string              row_name [NUM_ROWS];
  int                 row_fill;
  hl_ctrl_pkg::ctrl_t prev_ctrl;
  logic [31:0]        lcg_state;
  int                 err_count;
  int                 test_count;
  int                 failed_tests;
  int                 cycle_count;
  int                 xfer_count;

  tb_clkgen tb_clkgen_i (
    .clk_o    (clk_ctrl),
    .arst_n_o (arst_n_i)
  );

  hl_ctrl_top hl_ctrl_top_i (
    .clk_ctrl      (clk_ctrl),
    .arst_n_i      (arst_n_i),
    .cmd_i         (cmd_i),
    .cmd_cnt_i     (cmd_cnt_i),
    .status_i      (status_i),
    .ctrl_o        (ctrl_o),
    .resp_o        (resp_o),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .rxclrstatus_o (rxclrstatus_o)
  );

  bind hl_ctrl_top hl_ctrl_properties hl_ctrl_properties_i (
    .clk_ctrl      (clk_ctrl),
    .arst_n_i      (arst_n_i),
    .ctrl_i        (ctrl_o),
    .resp_i        (resp_o),
    .resp_valid_i  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .rxclrstatus_i (rxclrstatus_o)
  );

  ////////////////////
  // Cycle limit and transfer count

  always @(posedge clk_ctrl) begin
    cycle_count++;
    if (resp_valid_o && resp_ready_i) begin
      xfer_count++;
    end
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Drive level 31:24, PA enable 19, rest random
  function automatic logic [31:0] drive_word(input logic [7:0] drv, input logic pa_en);
    logic [31:0] w;
    w        = lcg_next();
    w[31:24] = drv;
    w[19]    = pa_en;
    return w;
  endfunction

  // Gain 5:0, override 6, rest random
  function automatic logic [31:0] gain_word(input logic [5:0] gain, input logic ovr);
    logic [31:0] w;
    w      = lcg_next();
    w[5:0] = gain;
    w[6]   = ovr;
    return w;
  endfunction

  task automatic next_cycle();
    @(posedge clk_ctrl);
    #1;
  endtask

  task automatic send_cmd(input hl_ctrl_pkg::cmd_t cmd);
    cmd_i     = cmd;
    cmd_cnt_i = ~cmd_cnt_i;
  endtask

  ////////////////////
  // Compare tasks

  task automatic check_ctrl(input string name, input hl_ctrl_pkg::ctrl_t exp,
                            input hl_ctrl_pkg::ctrl_t act);
    if (act !== exp) begin
      $display("ERR %s: ctrl_o expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_resp(input string name, input hl_ctrl_pkg::resp_t exp,
                            input hl_ctrl_pkg::resp_t act);
    if (act !== exp) begin
      $display("ERR %s: resp_o expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("ERR %s: %s expected %b, actual %b", name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count != errs_before) begin
      failed_tests++;
      $display("test %-12s FAILED", name);
    end else begin
      $display("test %-12s ok", name);
    end
  endtask

  task automatic add_row(input string name, input hl_ctrl_pkg::cmd_t cmd,
                         input hl_ctrl_pkg::rx_status_t st, input logic [1:0] mode,
                         input hl_ctrl_pkg::ctrl_t ec, input hl_ctrl_pkg::resp_t er);
    row_name[row_fill] = name;
    rows[row_fill]     = {cmd, st, mode, ec, er};
    row_fill++;
  endtask

  ////////////////////
  // Stimulus table

  // cmd {addr, data, ptt, resp_req}, status {clip, good_lvl}
  // ctrl {tx_on, pa_tr, drive, gain, override}, resp {addr, clip, good_lvl, readback}
  task automatic build_table();
    logic [31:0] w;
    w = drive_word(8'ha5, 1'b1);
    add_row("drive_ptt", {A_DRV, w, 1'b1, 1'b0}, 2'b00, RDY_NONE,
            {1'b1, 1'b1, 8'ha5, 6'h00, 1'b0}, '0);
    w = drive_word(8'h3c, 1'b1);
    add_row("drive_rx", {A_DRV, w, 1'b0, 1'b0}, 2'b00, RDY_NONE,
            {1'b0, 1'b0, 8'h3c, 6'h00, 1'b0}, '0);
    w = gain_word(6'h2a, 1'b1);
    add_row("gain_req", {A_GAIN, w, 1'b1, 1'b1}, 2'b00, RDY_NOW,
            {1'b1, 1'b1, 8'h3c, 6'h2a, 1'b1}, {A_GAIN, 1'b0, 1'b0, w});
    w = lcg_next();
    add_row("unknown_req", {A_UNK, w, 1'b0, 1'b1}, 2'b00, RDY_NOW,
            {1'b0, 1'b0, 8'h3c, 6'h2a, 1'b1}, {A_UNK, 1'b0, 1'b0, 32'h0});
    w = drive_word(8'h80, 1'b0);
    add_row("clip_set", {A_DRV, w, 1'b1, 1'b1}, 2'b10, RDY_NOW,
            {1'b1, 1'b0, 8'h80, 6'h2a, 1'b1}, {A_DRV, 1'b1, 1'b0, w});
    w = gain_word(6'h15, 1'b0);
    add_row("clip_clear", {A_GAIN, w, 1'b1, 1'b1}, 2'b00, RDY_NOW,
            {1'b1, 1'b0, 8'h80, 6'h15, 1'b0}, {A_GAIN, 1'b0, 1'b0, w});
    w = drive_word(8'hff, 1'b1);
    add_row("hold", {A_DRV, w, 1'b1, 1'b1}, 2'b01, RDY_HOLD,
            {1'b1, 1'b1, 8'hff, 6'h15, 1'b0}, {A_DRV, 1'b0, 1'b1, w});
  endtask

  task automatic run_row(input int r);
    row_t row;
    int   errs_before;
    int   waited;
    int   xfers_before;
    row         = rows[r];
    errs_before = err_count;
    // Status pulse, then quiet inputs before the command
    status_i = row.status;
    repeat (3) next_cycle();
    status_i = '0;
    repeat (3) next_cycle();
    send_cmd(row.cmd);
    repeat (2) next_cycle();
    check_ctrl({row_name[r], " early"}, prev_ctrl, ctrl_o);
    next_cycle();
    check_ctrl(row_name[r], row.exp_ctrl, ctrl_o);
    prev_ctrl = row.exp_ctrl;
    if (row.ready_mode == RDY_NONE) begin
      next_cycle();
      check_flag(row_name[r], "resp_valid_o", 1'b0, resp_valid_o);
    end else begin
      waited = 0;
      while (!resp_valid_o && waited < 4) begin
        next_cycle();
        waited++;
      end
      if (!resp_valid_o) begin
        $display("Test %s: no response came back for the command", row_name[r]);
        err_count++;
      end else begin
        check_resp(row_name[r], row.exp_resp, resp_o);
        if (row.ready_mode == RDY_HOLD) begin
          repeat (3) next_cycle();
          // Second request lands on a pending response
          send_cmd({A_NONE, lcg_next(), row.cmd.ptt, 1'b1});
          repeat (4) next_cycle();
          check_resp({row_name[r], " held"}, row.exp_resp, resp_o);
          check_ctrl({row_name[r], " held"}, row.exp_ctrl, ctrl_o);
        end
        xfers_before = xfer_count;
        resp_ready_i = 1'b1;
        next_cycle();
        // Cycle after the transfer
        check_flag(row_name[r], "resp_valid_o", 1'b0, resp_valid_o);
        check_flag(row_name[r], "rxclrstatus_o", 1'b1, rxclrstatus_o);
        next_cycle();
        check_flag(row_name[r], "rxclrstatus_o", 1'b0, rxclrstatus_o);
        resp_ready_i = 1'b0;
        if (xfer_count - xfers_before != 1) begin
          $display("ERR %s: transfers expected 1, actual %0d", row_name[r],
                   xfer_count - xfers_before);
          err_count++;
        end
      end
    end
    report_test(row_name[r], errs_before);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    cmd_i        = '0;
    cmd_cnt_i    = 1'b0;
    status_i     = '0;
    resp_ready_i = 1'b0;
    lcg_state    = SEED;
    prev_ctrl    = '0;
    row_fill     = 0;
    build_table();
    @(posedge arst_n_i);
    next_cycle();
    check_ctrl("reset", '0, ctrl_o);
    check_resp("reset", '0, resp_o);
    check_flag("reset", "resp_valid_o", 1'b0, resp_valid_o);
    check_flag("reset", "rxclrstatus_o", 1'b0, rxclrstatus_o);
    report_test("reset", 0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* test/tb_clkgen.sv */
/*
 * Control clock and power-on reset for the testbench
 */
module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    // Reset held across 4 rising edges
    repeat (4) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

/* verilog/cmd_sync.sv */
/*
 * Command count toggle synchronizer and strobe generator
 * Receiver status level synchronizers
 */
`include "hl_ctrl_config.svh"

module cmd_sync (
  input  logic                    clk_ctrl,
  input  logic                    arst_n_i,
  input  hl_ctrl_pkg::cmd_t       cmd_i,
  input  logic                    cmd_cnt_i,
  input  hl_ctrl_pkg::rx_status_t status_i,
  output logic                    cmd_stb_o,
  output hl_ctrl_pkg::cmd_t       cmd_o,
  output hl_ctrl_pkg::rx_status_t status_o
);

  // Count bit on top, status bits below it
  localparam int SYNC_W = 1 + $bits(hl_ctrl_pkg::rx_status_t);
  localparam int LAST   = `HL_SYNC_DEPTH - 1;

  logic [`HL_SYNC_DEPTH-1:0][SYNC_W-1:0] sync_q;
  logic                                  cnt_last_q;
  logic                                  cnt_sync;
  logic                                  cnt_advance;
  hl_ctrl_pkg::cmd_t                     cmd_q;

  ////////////////////
  // Synchronizer chains

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= {cmd_cnt_i, status_i};
      for (int i = 1; i < `HL_SYNC_DEPTH; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign cnt_sync = sync_q[LAST][SYNC_W-1];

  // Toggle about to enter the last stage
  assign cnt_advance = sync_q[LAST-1][SYNC_W-1] ^ cnt_sync;

  ////////////////////
  // Toggle detect

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_last_q <= 1'b0;
    end else begin
      cnt_last_q <= cnt_sync;
    end
  end

  // One cycle per toggle, either direction
  assign cmd_stb_o = cnt_sync ^ cnt_last_q;

  // Command bus has been stable since before the toggle,
  // so it is taken on the edge that raises the strobe
  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_q <= '0;
    end else if (cnt_advance) begin
      cmd_q <= cmd_i;
    end
  end

  assign cmd_o    = cmd_q;
  assign status_o = sync_q[LAST][SYNC_W-2:0];

endmodule

/* verilog/ctrl_regs.sv */
/*
 * Transmit drive and receive gain registers
 * PTT and PA keying, readback select
 */
`include "hl_ctrl_config.svh"

module ctrl_regs (
  input  logic                   clk_ctrl,
  input  logic                   arst_n_i,
  input  logic                   cmd_stb_i,
  input  hl_ctrl_pkg::cmd_t      cmd_i,
  output hl_ctrl_pkg::ctrl_t     ctrl_o,
  output logic [`HL_DATA_W-1:0]  readback_o
);

  hl_ctrl_pkg::cmd_data_u drive_q;
  hl_ctrl_pkg::cmd_data_u drive_d;
  hl_ctrl_pkg::cmd_data_u gain_q;
  hl_ctrl_pkg::cmd_data_u gain_d;
  logic                   tx_on_q;
  logic                   drive_hit;
  logic                   gain_hit;

  ////////////////////
  // Address decode

  assign drive_hit = cmd_stb_i && (cmd_i.addr == `HL_ADDR_W'(`HL_ADDR_TXDRV));
  assign gain_hit  = cmd_stb_i && (cmd_i.addr == `HL_ADDR_W'(`HL_ADDR_GAIN));

  // Next register values
  always_comb begin
    drive_d = drive_q;
    gain_d  = gain_q;
    if (drive_hit) begin
      drive_d = cmd_i.data;
    end
    if (gain_hit) begin
      gain_d = cmd_i.data;
    end
  end

  ////////////////////
  // Registers

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      drive_q <= '0;
      gain_q  <= '0;
    end else begin
      drive_q <= drive_d;
      gain_q  <= gain_d;
    end
  end

  // PTT follows every command, whatever the address
  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_on_q <= 1'b0;
    end else if (cmd_stb_i) begin
      tx_on_q <= cmd_i.ptt;
    end
  end

  ////////////////////
  // Outputs

  assign ctrl_o.tx_on = tx_on_q;

  // PA keyed only while transmitting
  assign ctrl_o.pa_tr         = tx_on_q & drive_q.drive_view.pa_en;
  assign ctrl_o.drive         = drive_q.drive_view.drive;
  assign ctrl_o.gain          = gain_q.gain_view.gain;
  assign ctrl_o.gain_override = gain_q.gain_view.gain_override;

  // Post-update word, reserved bits included
  always_comb begin
    case (cmd_i.addr)
      `HL_ADDR_W'(`HL_ADDR_TXDRV): begin
        readback_o = drive_d;
      end
      `HL_ADDR_W'(`HL_ADDR_GAIN): begin
        readback_o = gain_d;
      end
      default: begin
        readback_o = '0;
      end
    endcase
  end

endmodule

/* verilog/hl_ctrl_config.svh */
/*
 * Command addresses, field widths, data word bit positions
 * and synchronizer depth for the control path
 */
`ifndef HL_CTRL_CONFIG_SVH
`define HL_CTRL_CONFIG_SVH

////////////////////
// Command bus

`define HL_ADDR_W       6
`define HL_DATA_W       32

// Register addresses
`define HL_ADDR_TXDRV   9
`define HL_ADDR_GAIN    10

////////////////////
// Data word fields

`define HL_DRIVE_W      8
`define HL_DRIVE_LSB    24
`define HL_PA_EN_BIT    19
`define HL_GAIN_W       6
`define HL_GAIN_OVR_BIT 6

// Flops per synchronizer chain
`define HL_SYNC_DEPTH   2

`define HL_RESP_W       40

`endif

/* verilog/hl_ctrl_pkg.sv */
/*
 * Command, control, status and response structs
 * Two-view union for the command data word
 */
`include "hl_ctrl_config.svh"

package hl_ctrl_pkg;

  ////////////////////
  // Command side

  // Host command as it arrives, framed by the count toggle
  typedef struct packed {
    logic [`HL_ADDR_W-1:0] addr;
    logic [`HL_DATA_W-1:0] data;
    logic                  ptt;
    logic                  resp_req;
  } cmd_t;

  // Transmit drive word
  typedef struct packed {
    logic [`HL_DRIVE_W-1:0]                    drive;
    logic [`HL_DRIVE_LSB-`HL_PA_EN_BIT-2:0]    rsvd_hi;
    logic                                      pa_en;
    logic [`HL_PA_EN_BIT-1:0]                  rsvd_lo;
  } drive_view_t;

  // Receive gain word
  typedef struct packed {
    logic [`HL_DATA_W-`HL_GAIN_OVR_BIT-2:0]    rsvd;
    logic                                      gain_override;
    logic [`HL_GAIN_W-1:0]                     gain;
  } gain_view_t;

  // Same 32-bit data word, decoded per address
  typedef union packed {
    drive_view_t drive_view;
    gain_view_t  gain_view;
  } cmd_data_u;

  ////////////////////
  // Radio side

  typedef struct packed {
    logic                   tx_on;
    logic                   pa_tr;
    logic [`HL_DRIVE_W-1:0] drive;
    logic [`HL_GAIN_W-1:0]  gain;
    logic                   gain_override;
  } ctrl_t;

  typedef struct packed {
    logic clip;
    logic good_lvl;
  } rx_status_t;

  // Answer to a response-wanted command
  typedef struct packed {
    logic [`HL_ADDR_W-1:0] addr;
    logic                  clip;
    logic                  good_lvl;
    logic [`HL_DATA_W-1:0] readback;
  } resp_t;

endpackage

/* verilog/hl_ctrl_top.sv */
/*
 * Control-domain command path top level
 * Synchronizer, register block and responder
 */
`include "hl_ctrl_config.svh"

module hl_ctrl_top (
  input  logic                    clk_ctrl,
  input  logic                    arst_n_i,
  input  hl_ctrl_pkg::cmd_t       cmd_i,
  input  logic                    cmd_cnt_i,
  input  hl_ctrl_pkg::rx_status_t status_i,
  output hl_ctrl_pkg::ctrl_t      ctrl_o,
  output hl_ctrl_pkg::resp_t      resp_o,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output logic                    rxclrstatus_o
);

  logic                    cmd_stb;
  hl_ctrl_pkg::cmd_t       cmd;
  hl_ctrl_pkg::rx_status_t status_sync;
  logic [`HL_DATA_W-1:0]   readback;

  ////////////////////
  // Into clk_ctrl

  cmd_sync cmd_sync_i (
    .clk_ctrl  (clk_ctrl),
    .arst_n_i  (arst_n_i),
    .cmd_i     (cmd_i),
    .cmd_cnt_i (cmd_cnt_i),
    .status_i  (status_i),
    .cmd_stb_o (cmd_stb),
    .cmd_o     (cmd),
    .status_o  (status_sync)
  );

  ////////////////////
  // Radio settings

  ctrl_regs ctrl_regs_i (
    .clk_ctrl   (clk_ctrl),
    .arst_n_i   (arst_n_i),
    .cmd_stb_i  (cmd_stb),
    .cmd_i      (cmd),
    .ctrl_o     (ctrl_o),
    .readback_o (readback)
  );

  // Status and response
  status_resp status_resp_i (
    .clk_ctrl      (clk_ctrl),
    .arst_n_i      (arst_n_i),
    .cmd_stb_i     (cmd_stb),
    .cmd_i         (cmd),
    .status_i      (status_sync),
    .readback_i    (readback),
    .resp_o        (resp_o),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .rxclrstatus_o (rxclrstatus_o)
  );

endmodule

/* verilog/status_resp.sv */
/*
 * Sticky receiver clip and good-level flags
 * Response capture with valid/ready handshake
 */
`include "hl_ctrl_config.svh"

module status_resp (
  input  logic                    clk_ctrl,
  input  logic                    arst_n_i,
  input  logic                    cmd_stb_i,
  input  hl_ctrl_pkg::cmd_t       cmd_i,
  input  hl_ctrl_pkg::rx_status_t status_i,
  input  logic [`HL_DATA_W-1:0]   readback_i,
  output hl_ctrl_pkg::resp_t      resp_o,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output logic                    rxclrstatus_o
);

  logic                  clip_q;
  logic                  good_lvl_q;
  logic                  resp_valid_q;
  logic                  rxclr_q;
  hl_ctrl_pkg::resp_t    resp_q;
  logic                  xfer;
  logic                  capture;
  logic [`HL_RESP_W-1:0] resp_d;

  assign xfer = resp_valid_q & resp_ready_i;

  // Requests seen while a response is pending are dropped
  assign capture = cmd_stb_i & cmd_i.resp_req & ~resp_valid_q;

  assign resp_d = {cmd_i.addr, clip_q, good_lvl_q, readback_i};

  ////////////////////
  // Sticky flags

  // Set by level, cleared by a transfer unless still asserted
  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clip_q     <= 1'b0;
      good_lvl_q <= 1'b0;
    end else begin
      clip_q     <= (clip_q & ~xfer) | status_i.clip;
      good_lvl_q <= (good_lvl_q & ~xfer) | status_i.good_lvl;
    end
  end

  ////////////////////
  // Response

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_q       <= '0;
      resp_valid_q <= 1'b0;
    end else if (capture) begin
      resp_q       <= resp_d;
      resp_valid_q <= 1'b1;
    end else if (xfer) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Clear pulse lands on the cycle after the transfer
  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rxclr_q <= 1'b0;
    end else begin
      rxclr_q <= xfer;
    end
  end

  assign resp_o        = resp_q;
  assign resp_valid_o  = resp_valid_q;
  assign rxclrstatus_o = rxclr_q;

endmodule
